//--- rtl/rv32i_bp_pkg.sv
package rv32i_bp_pkg;

    typedef logic [31:0] rv32i_word;                    // plain machine word

    // instruction class seen in execute, encoded as the RV32I opcode field
    typedef enum logic [6:0] {
        op_br    = 7'b1100011,                          // beq/bne/blt/bge/bltu/bgeu
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_other = 7'b0010011                           // never redirects
    } rv32i_opcode;

    // branch compare select, encoded as funct3
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct;

    // resolved outcome of the instr in execute
    typedef struct packed {
        rv32i_word   pc;                                // execute pc
        rv32i_opcode opcode;
        logic        taken;                             // resolved direction
        rv32i_word   target;                            // resolved destination
    } exe_info_t;

    // answer to the fetch lookup
    typedef struct packed {
        logic      prediction;                          // 1 = redirect fetch
        rv32i_word target;                              // all ones when not predicting
    } fetch_pred_t;

    localparam int HIST_W = 10;                         // branch and prediction history width

    // history at or above this predicts taken
    localparam logic [HIST_W-1:0] TAKEN_THRESH = 10'b11_1000_0000;

    // history below this predicts not taken
    localparam logic [HIST_W-1:0] NOT_TAKEN_THRESH = 10'd16;

    // middle band flips its last guess when more than this many bits disagree
    localparam int MISS_LIMIT = 5;

    localparam rv32i_word INVALID_TARGET = 32'hffff_ffff;   // no-prediction target

endpackage : rv32i_bp_pkg

//--- rtl/btb_entry.sv
module btb_entry (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    alloc,              // overwrite with the branch in execute
    input  logic                    upd_hist,           // shift in a new outcome
    input  logic                    taken,              // resolved direction in execute
    input  rv32i_bp_pkg::rv32i_word pc_exe,
    input  rv32i_bp_pkg::rv32i_word pc_fetch,
    input  logic [12:0]             imm_off,            // b-type immediate, bit 0 always zero
    output logic                    fetch_hit,
    output logic                    exe_hit,
    output logic                    predict,
    output rv32i_bp_pkg::rv32i_word target
);

    logic                              valid;
    rv32i_bp_pkg::rv32i_word           tag;             // pc of the branch held here
    logic [12:0]                       off;             // branch offset
    logic [rv32i_bp_pkg::HIST_W-1:0]   hist;            // msb is the most recent outcome
    logic [rv32i_bp_pkg::HIST_W-1:0]   phist;           // msb is the most recent own guess
    logic                              too_many_miss;

    assign fetch_hit = valid && (tag == pc_fetch);
    assign exe_hit   = valid && (tag == pc_exe);

    assign target = tag + {{19{off[12]}}, off};         // sign extend the 13-bit offset

    // count of positions where outcome and guess disagreed
    assign too_many_miss = ($countones(hist ^ phist) > rv32i_bp_pkg::MISS_LIMIT);

    always_comb begin
        if (hist >= rv32i_bp_pkg::TAKEN_THRESH) begin
            predict = 1'b1;                             // strongly taken lately
        end else if (hist < rv32i_bp_pkg::NOT_TAKEN_THRESH) begin
            predict = 1'b0;                             // almost never taken lately
        end else if (too_many_miss) begin
            predict = ~phist[rv32i_bp_pkg::HIST_W-1];   // last guess keeps missing, flip it
        end else begin
            predict = phist[rv32i_bp_pkg::HIST_W-1];    // stick with last guess
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            hist  <= '0;
            phist <= '0;
        end else if (alloc) begin
            valid <= 1'b1;
            hist  <= {1'b1, {(rv32i_bp_pkg::HIST_W-1){1'b0}}};  // allocated because taken
            phist <= '0;
        end else if (upd_hist) begin
            hist  <= {taken, hist[rv32i_bp_pkg::HIST_W-1:1]};
            phist <= {predict, phist[rv32i_bp_pkg::HIST_W-1:1]};    // own guess, not fetch's
        end
    end

    // payload, only meaningful while valid
    always_ff @(posedge clk) begin
        if (alloc) begin
            tag <= pc_exe;
            off <= imm_off;
        end
    end

endmodule : btb_entry

//--- rtl/jtb_entry.sv
module jtb_entry (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    alloc,              // overwrite with the jump in execute
    input  rv32i_bp_pkg::rv32i_word pc_exe,
    input  rv32i_bp_pkg::rv32i_word pc_fetch,
    input  rv32i_bp_pkg::rv32i_word new_target,         // resolved jump destination
    output logic                    fetch_hit,
    output logic                    exe_hit,
    output rv32i_bp_pkg::rv32i_word target
);

    logic                    valid;
    rv32i_bp_pkg::rv32i_word tag;                       // pc of the jump held here
    rv32i_bp_pkg::rv32i_word dest;                      // full target, no offset math

    assign fetch_hit = valid && (tag == pc_fetch);
    assign exe_hit   = valid && (tag == pc_exe);
    assign target    = dest;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (alloc) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag  <= pc_exe;
            dest <= new_target;                         // jalr target may change, first one sticks
        end
    end

endmodule : jtb_entry

//--- rtl/control_buffer.sv
module control_buffer #(
    parameter int BTB_ENTRIES = 32,
    parameter int JTB_ENTRIES = 16
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sel,              // one cycle per instr in execute
    input  rv32i_bp_pkg::exe_info_t   exe,
    input  logic [12:0]               imm_off,          // branch offset for allocation
    input  rv32i_bp_pkg::rv32i_word   pc_fetch,
    output rv32i_bp_pkg::fetch_pred_t pred
);

    localparam int BIDX_W = $clog2(BTB_ENTRIES);
    localparam int JIDX_W = $clog2(JTB_ENTRIES);

    logic [BTB_ENTRIES-1:0]  br_fetch_hits, br_exe_hits, br_predicts;
    logic [BTB_ENTRIES-1:0]  br_alloc, br_upd;         // per-entry strobes
    logic [JTB_ENTRIES-1:0]  jp_fetch_hits, jp_exe_hits;
    logic [JTB_ENTRIES-1:0]  jp_alloc;
    rv32i_bp_pkg::rv32i_word br_targets [BTB_ENTRIES];
    rv32i_bp_pkg::rv32i_word jp_targets [JTB_ENTRIES];

    logic [BIDX_W-1:0] btb_head, br_fetch_idx, br_exe_idx;
    logic [JIDX_W-1:0] jtb_head, jp_fetch_idx;
    logic              is_br, is_jmp;
    logic              br_adv, jp_adv;                  // head moves this edge

    for (genvar g = 0; g < BTB_ENTRIES; g++) begin : g_btb
        btb_entry u_entry (
            .clk       (clk),
            .rst       (rst),
            .alloc     (br_alloc[g]),
            .upd_hist  (br_upd[g]),
            .taken     (exe.taken),
            .pc_exe    (exe.pc),
            .pc_fetch  (pc_fetch),
            .imm_off   (imm_off),
            .fetch_hit (br_fetch_hits[g]),
            .exe_hit   (br_exe_hits[g]),
            .predict   (br_predicts[g]),
            .target    (br_targets[g])
        );
    end

    for (genvar g = 0; g < JTB_ENTRIES; g++) begin : g_jtb
        jtb_entry u_entry (
            .clk        (clk),
            .rst        (rst),
            .alloc      (jp_alloc[g]),
            .pc_exe     (exe.pc),
            .pc_fetch   (pc_fetch),
            .new_target (exe.target),
            .fetch_hit  (jp_fetch_hits[g]),
            .exe_hit    (jp_exe_hits[g]),
            .target     (jp_targets[g])
        );
    end

    // priority encoders, scanning down so the lowest index wins
    always_comb begin
        br_fetch_idx = '0;
        br_exe_idx   = '0;
        for (int k = BTB_ENTRIES - 1; k >= 0; k--) begin
            if (br_fetch_hits[k]) begin
                br_fetch_idx = BIDX_W'(k);
            end
            if (br_exe_hits[k]) begin
                br_exe_idx = BIDX_W'(k);
            end
        end
        jp_fetch_idx = '0;
        for (int k = JTB_ENTRIES - 1; k >= 0; k--) begin
            if (jp_fetch_hits[k]) begin
                jp_fetch_idx = JIDX_W'(k);
            end
        end
    end

    // fetch lookup, branch table has priority over jump table
    always_comb begin
        pred.prediction = 1'b0;
        pred.target     = rv32i_bp_pkg::INVALID_TARGET;
        if (|br_fetch_hits) begin
            pred.prediction = br_predicts[br_fetch_idx];    // may be not taken
            if (br_predicts[br_fetch_idx]) begin
                pred.target = br_targets[br_fetch_idx];
            end
        end else if (|jp_fetch_hits) begin
            pred.prediction = 1'b1;                     // jumps always redirect
            pred.target     = jp_targets[jp_fetch_idx];
        end
    end

    assign is_br  = (exe.opcode == rv32i_bp_pkg::op_br);
    assign is_jmp = (exe.opcode == rv32i_bp_pkg::op_jal) ||
                    (exe.opcode == rv32i_bp_pkg::op_jalr);

    assign br_adv = sel && is_br && !(|br_exe_hits) && exe.taken;  // only taken misses allocate
    assign jp_adv = sel && is_jmp && !(|jp_exe_hits);

    // update strobes, all quiet unless sel
    always_comb begin
        br_alloc = '0;
        br_upd   = '0;
        jp_alloc = '0;
        if (sel && is_br && (|br_exe_hits)) begin
            br_upd[br_exe_idx] = 1'b1;                  // known branch, learn outcome
        end
        if (br_adv) begin
            br_alloc[btb_head] = 1'b1;                  // evict oldest
        end
        if (jp_adv) begin
            jp_alloc[jtb_head] = 1'b1;
        end
    end

    // fifo heads, wrap at table size
    always_ff @(posedge clk) begin
        if (rst) begin
            btb_head <= '0;
            jtb_head <= '0;
        end else begin
            if (br_adv) begin
                btb_head <= (btb_head == BIDX_W'(BTB_ENTRIES - 1)) ? '0 : btb_head + 1'b1;
            end
            if (jp_adv) begin
                jtb_head <= (jtb_head == JIDX_W'(JTB_ENTRIES - 1)) ? '0 : jtb_head + 1'b1;
            end
        end
    end

endmodule : control_buffer

//--- rtl/branch_resolve.sv
module branch_resolve (
    input  rv32i_bp_pkg::rv32i_word   pc_exe,
    input  rv32i_bp_pkg::rv32i_opcode opcode,
    input  rv32i_bp_pkg::branch_funct funct,
    input  rv32i_bp_pkg::rv32i_word   rs1,
    input  rv32i_bp_pkg::rv32i_word   rs2,
    input  rv32i_bp_pkg::rv32i_word   imm,
    output rv32i_bp_pkg::exe_info_t   exe,
    output logic [12:0]               imm_off           // b-type offset bits for the btb
);

    logic                    eq, lt_s, lt_u;
    logic                    cmp;                       // branch condition from funct3
    rv32i_bp_pkg::rv32i_word pc_sum, reg_sum;

    assign eq   = (rs1 == rs2);
    assign lt_s = ($signed(rs1) < $signed(rs2));
    assign lt_u = (rs1 < rs2);

    assign pc_sum  = pc_exe + imm;                      // branches and jal
    assign reg_sum = rs1 + imm;                         // jalr before lsb clear

    always_comb begin
        case (funct)
            rv32i_bp_pkg::beq:  cmp = eq;
            rv32i_bp_pkg::bne:  cmp = !eq;
            rv32i_bp_pkg::blt:  cmp = lt_s;
            rv32i_bp_pkg::bge:  cmp = !lt_s;
            rv32i_bp_pkg::bltu: cmp = lt_u;
            rv32i_bp_pkg::bgeu: cmp = !lt_u;
            default:            cmp = 1'b0;             // reserved funct3 never branches
        endcase
    end

    always_comb begin
        exe.pc     = pc_exe;
        exe.opcode = opcode;
        exe.target = pc_sum;
        case (opcode)
            rv32i_bp_pkg::op_br: begin
                exe.taken = cmp;
            end
            rv32i_bp_pkg::op_jal: begin
                exe.taken = 1'b1;
            end
            rv32i_bp_pkg::op_jalr: begin
                exe.taken  = 1'b1;
                exe.target = {reg_sum[31:1], 1'b0};     // spec clears bit 0
            end
            default: begin
                exe.taken = 1'b0;                       // op_other
            end
        endcase
    end

    assign imm_off = imm[12:0];

endmodule : branch_resolve

//--- rtl/bp_top.sv
module bp_top #(
    parameter int BTB_ENTRIES = 32,
    parameter int JTB_ENTRIES = 16
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sel,              // first cycle of the instr in execute
    input  rv32i_bp_pkg::rv32i_word   pc_exe,
    input  rv32i_bp_pkg::rv32i_opcode opcode,
    input  rv32i_bp_pkg::branch_funct funct,
    input  rv32i_bp_pkg::rv32i_word   rs1,
    input  rv32i_bp_pkg::rv32i_word   rs2,
    input  rv32i_bp_pkg::rv32i_word   imm,
    input  rv32i_bp_pkg::rv32i_word   pc_fetch,
    output rv32i_bp_pkg::fetch_pred_t pred,
    output logic                      exe_taken,        // redirect request from execute
    output rv32i_bp_pkg::rv32i_word   exe_target
);

    rv32i_bp_pkg::exe_info_t exe;
    logic [12:0]             imm_off;

    branch_resolve u_resolve (
        .pc_exe  (pc_exe),
        .opcode  (opcode),
        .funct   (funct),
        .rs1     (rs1),
        .rs2     (rs2),
        .imm     (imm),
        .exe     (exe),
        .imm_off (imm_off)
    );

    control_buffer #(
        .BTB_ENTRIES (BTB_ENTRIES),
        .JTB_ENTRIES (JTB_ENTRIES)
    ) u_buffer (
        .clk      (clk),
        .rst      (rst),
        .sel      (sel),
        .exe      (exe),
        .imm_off  (imm_off),
        .pc_fetch (pc_fetch),
        .pred     (pred)
    );

    assign exe_taken  = exe.taken;
    assign exe_target = exe.target;

endmodule : bp_top

//--- verif/bp_chk.sv
module bp_chk #(
    parameter int BIDX_W = 5,
    parameter int JIDX_W = 4
) (
    input logic                    clk,
    input logic                    rst,
    input logic                    sel,
    input rv32i_bp_pkg::exe_info_t exe,
    input logic                    any_br_hit,
    input logic                    any_jp_hit,
    input logic [BIDX_W-1:0]       btb_head,
    input logic [JIDX_W-1:0]       jtb_head,
    input logic                    any_strobe       // or of all alloc and history strobes
);

    logic br_miss_taken, jp_miss;
    int   fails = 0;                                // assertion failures so far

    assign br_miss_taken = sel && exe.opcode == rv32i_bp_pkg::op_br && !any_br_hit && exe.taken;
    assign jp_miss       = sel && !any_jp_hit &&
                           (exe.opcode == rv32i_bp_pkg::op_jal ||
                            exe.opcode == rv32i_bp_pkg::op_jalr);

    a_br_head: assert property (@(posedge clk) disable iff (rst)
        !br_miss_taken |=> btb_head == $past(btb_head))
        else begin
            fails++;
            $error("branch head moved without a taken miss");
        end

    a_jp_head: assert property (@(posedge clk) disable iff (rst)
        !jp_miss |=> jtb_head == $past(jtb_head))
        else begin
            fails++;
            $error("jump head moved without a jump miss");
        end

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        !sel |-> !any_strobe)
        else begin
            fails++;
            $error("update strobe without sel");
        end

endmodule : bp_chk

bind control_buffer bp_chk #(.BIDX_W(BIDX_W), .JIDX_W(JIDX_W)) u_chk (
    .clk        (clk),
    .rst        (rst),
    .sel        (sel),
    .exe        (exe),
    .any_br_hit (|br_exe_hits),
    .any_jp_hit (|jp_exe_hits),
    .btb_head   (btb_head),
    .jtb_head   (jtb_head),
    .any_strobe ((|br_alloc) || (|br_upd) || (|jp_alloc))
);

//--- verif/bp_monitor.sv
module bp_monitor #(
    parameter int BTB_ENTRIES = 32,
    parameter int JTB_ENTRIES = 16
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sel,
    input  rv32i_bp_pkg::rv32i_word   pc_exe,
    input  rv32i_bp_pkg::rv32i_opcode opcode,
    input  rv32i_bp_pkg::branch_funct funct,
    input  rv32i_bp_pkg::rv32i_word   rs1,
    input  rv32i_bp_pkg::rv32i_word   rs2,
    input  rv32i_bp_pkg::rv32i_word   imm,
    input  rv32i_bp_pkg::rv32i_word   pc_fetch,
    input  rv32i_bp_pkg::fetch_pred_t pred,
    input  logic                      exe_taken,
    input  rv32i_bp_pkg::rv32i_word   exe_target,
    output int                        errors,
    output int                        updates           // sel edges seen
);

    // model of the branch table
    logic        bvalid [BTB_ENTRIES];
    logic [31:0] btag   [BTB_ENTRIES];
    logic [12:0] boff   [BTB_ENTRIES];
    logic [9:0]  bhist  [BTB_ENTRIES];
    logic [9:0]  bphist [BTB_ENTRIES];
    int          bhead;
    // model of the jump table
    logic        jvalid [JTB_ENTRIES];
    logic [31:0] jtag   [JTB_ENTRIES];
    logic [31:0] jdest  [JTB_ENTRIES];
    int          jhead;

    // expected {taken, target} of the instr in execute
    function automatic logic [32:0] resolve_ref(logic [6:0] op, logic [2:0] f,
                                                logic [31:0] pc, logic [31:0] a,
                                                logic [31:0] b, logic [31:0] im);
        logic t;
        t = 1'b0;
        if (op == 7'b1100011) begin
            case (f)
                3'b000:  t = (a == b);
                3'b001:  t = (a != b);
                3'b100:  t = ($signed(a) < $signed(b));
                3'b101:  t = ($signed(a) >= $signed(b));
                3'b110:  t = (a < b);
                3'b111:  t = (a >= b);
                default: t = 1'b0;
            endcase
            return {t, pc + im};
        end else if (op == 7'b1101111) begin
            return {1'b1, pc + im};                     // jal
        end else if (op == 7'b1100111) begin
            return {1'b1, (a + im) & 32'hffff_fffe};    // jalr drops bit 0
        end
        return {1'b0, pc + im};
    endfunction

    // direction an entry guesses from its two histories
    function automatic logic entry_guess(int i);
        if (bhist[i] >= 10'b11_1000_0000) return 1'b1;
        if (bhist[i] < 10'd16) return 1'b0;
        if ($countones(bhist[i] ^ bphist[i]) > 5) return ~bphist[i][9];
        return bphist[i][9];
    endfunction

    // expected {prediction, target} at fetch, lowest index wins, branches first
    function automatic logic [32:0] fetch_ref(logic [31:0] pc);
        logic g;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            if (bvalid[i] && btag[i] == pc) begin
                g = entry_guess(i);
                return g ? {1'b1, btag[i] + {{19{boff[i][12]}}, boff[i]}} : {1'b0, 32'hffff_ffff};
            end
        end
        for (int i = 0; i < JTB_ENTRIES; i++) begin
            if (jvalid[i] && jtag[i] == pc) return {1'b1, jdest[i]};
        end
        return {1'b0, 32'hffff_ffff};
    endfunction

    initial begin
        errors  = 0;
        updates = 0;
    end

    // compare mid-cycle, inputs settled since the +1 drive
    always @(negedge clk) begin
        logic [32:0] exp_res, exp_pred;
        if (!rst) begin
            exp_res  = resolve_ref(opcode, funct, pc_exe, rs1, rs2, imm);
            exp_pred = fetch_ref(pc_fetch);
            if ({exe_taken, exe_target} !== exp_res) begin
                $display("ERROR %0t: resolve pc %h got %b/%h exp %b/%h", $time, pc_exe,
                         exe_taken, exe_target, exp_res[32], exp_res[31:0]);
                errors++;
            end
            if (pred !== exp_pred) begin
                $display("ERROR %0t: fetch pc %h got %b/%h exp %b/%h", $time, pc_fetch,
                         pred.prediction, pred.target, exp_pred[32], exp_pred[31:0]);
                errors++;
            end
        end
    end

    // model update on the sel edge
    always @(posedge clk) begin
        logic [32:0] res;
        int          hit;
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) bvalid[i] = 1'b0;
            for (int i = 0; i < JTB_ENTRIES; i++) jvalid[i] = 1'b0;
            bhead = 0;
            jhead = 0;
        end else if (sel) begin
            updates++;
            res = resolve_ref(opcode, funct, pc_exe, rs1, rs2, imm);
            hit = -1;
            if (opcode == rv32i_bp_pkg::op_br) begin
                for (int i = 0; i < BTB_ENTRIES; i++) begin
                    if (hit < 0 && bvalid[i] && btag[i] == pc_exe) hit = i;
                end
                if (hit >= 0) begin
                    bphist[hit] = {entry_guess(hit), bphist[hit][9:1]};  // guess before shift
                    bhist[hit]  = {res[32], bhist[hit][9:1]};
                end else if (res[32]) begin
                    bvalid[bhead] = 1'b1;
                    btag[bhead]   = pc_exe;
                    boff[bhead]   = imm[12:0];
                    bhist[bhead]  = 10'h200;
                    bphist[bhead] = '0;
                    bhead         = (bhead + 1) % BTB_ENTRIES;
                end
            end else if (opcode == rv32i_bp_pkg::op_jal || opcode == rv32i_bp_pkg::op_jalr) begin
                for (int i = 0; i < JTB_ENTRIES; i++) begin
                    if (jvalid[i] && jtag[i] == pc_exe) hit = i;
                end
                if (hit < 0) begin
                    jvalid[jhead] = 1'b1;
                    jtag[jhead]   = pc_exe;
                    jdest[jhead]  = res[31:0];
                    jhead         = (jhead + 1) % JTB_ENTRIES;
                end
            end
        end
    end

endmodule : bp_monitor

//--- verif/bp_tb.sv
module bp_tb;

    logic                      clk, rst, sel;
    rv32i_bp_pkg::rv32i_word   pc_exe, rs1, rs2, imm, pc_fetch;
    rv32i_bp_pkg::rv32i_opcode opcode;
    rv32i_bp_pkg::branch_funct funct;
    rv32i_bp_pkg::fetch_pred_t pred;
    logic                      exe_taken;
    rv32i_bp_pkg::rv32i_word   exe_target;
    int                        errors, updates;
    int                        seed;
    rv32i_bp_pkg::branch_funct fsel [6];

    bp_top #(.BTB_ENTRIES(32), .JTB_ENTRIES(16)) UUT (.*);

    bp_monitor #(.BTB_ENTRIES(32), .JTB_ENTRIES(16)) u_mon (.*);

    always #4 clk = ~clk;

    // sel high for one cycle while one instr sits in execute
    task automatic run_instr(rv32i_bp_pkg::rv32i_opcode op, rv32i_bp_pkg::branch_funct f,
                             logic [31:0] pc, logic [31:0] a, logic [31:0] b, logic [31:0] im);
        @(posedge clk);
        #1;
        opcode   = op;
        funct    = f;
        pc_exe   = pc;
        rs1      = a;
        rs2      = b;
        imm      = im;
        pc_fetch = pc;                                  // fetch looks at the same pc afterwards
        sel      = 1'b1;
        @(posedge clk);                                 // buffer learns on this edge
        #1;
        sel = 1'b0;
    endtask

    task automatic look_up(logic [31:0] pc);
        @(posedge clk);
        #1;
        pc_fetch = pc;
    endtask

    // one random branch or jump on a small pc set, then a random fetch
    task automatic run_random_instr();
        rv32i_bp_pkg::rv32i_opcode op;
        rv32i_bp_pkg::branch_funct f;
        logic [31:0]               pc, a, b;
        logic [12:0]               off;                 // b-type offset, bit 0 clear
        op  = (($random(seed) & 7) == 0) ? rv32i_bp_pkg::op_jal : rv32i_bp_pkg::op_br;
        f   = fsel[($random(seed) & 32'h7fff_ffff) % 6];
        pc  = 32'h3000 + 4 * ($random(seed) & 7);
        a   = $random(seed) & 3;
        b   = $random(seed) & 3;
        off = 13'($random(seed)) & 13'h1ffe;
        run_instr(op, f, pc, a, b, {{19{off[12]}}, off});   // sign extended like decode
        look_up(32'h3000 + 4 * ($random(seed) & 7));
    endtask

    initial begin
        clk      = 0;
        rst      = 1;
        sel      = 0;
        pc_exe   = 0;
        rs1      = 0;
        rs2      = 0;
        imm      = 0;
        pc_fetch = 0;
        opcode   = rv32i_bp_pkg::op_other;
        funct    = rv32i_bp_pkg::beq;
        seed     = 32'h49eee4e6;
        fsel = '{rv32i_bp_pkg::beq, rv32i_bp_pkg::bne, rv32i_bp_pkg::blt,
                 rv32i_bp_pkg::bge, rv32i_bp_pkg::bltu, rv32i_bp_pkg::bgeu};
        repeat (2) @(posedge clk);
        #1 rst = 0;
        look_up(32'h0);                                          // empty tables
        look_up(32'h100);
        for (int k = 0; k < 6; k++) begin                        // all six on signed and unsigned
            run_instr(rv32i_bp_pkg::op_br, fsel[k], 32'h40 + 4 * k, 32'hffff_fff0, 32'h5, 32'h20);
            run_instr(rv32i_bp_pkg::op_br, fsel[k], 32'h40 + 4 * k, 32'h7, 32'h7, 32'h20);
        end
        run_instr(rv32i_bp_pkg::op_jal, rv32i_bp_pkg::beq, 32'h200, 0, 0, 32'h80);
        run_instr(rv32i_bp_pkg::op_jal, rv32i_bp_pkg::beq, 32'h200, 0, 0, 32'h80);  // no new entry
        run_instr(rv32i_bp_pkg::op_jalr, rv32i_bp_pkg::beq, 32'h204, 32'h1001, 0, 32'h10);
        run_instr(rv32i_bp_pkg::op_other, rv32i_bp_pkg::beq, 32'h208, 0, 0, 32'h4);
        run_instr(rv32i_bp_pkg::op_br, rv32i_bp_pkg::beq, 32'h100, 1, 1, 32'hffff_fff0); // backward
        for (int k = 0; k < 12; k++) begin                       // decay to not taken
            run_instr(rv32i_bp_pkg::op_br, rv32i_bp_pkg::beq, 32'h100, 1, 2, 32'hffff_fff0);
        end
        for (int k = 0; k < 24; k++) begin                       // middle band patterns
            run_instr(rv32i_bp_pkg::op_br, rv32i_bp_pkg::bne, 32'h100, 32'(k % 3 == 0), 0,
                      32'hffff_fff0);
        end
        run_instr(rv32i_bp_pkg::op_jal, rv32i_bp_pkg::beq, 32'h300, 0, 0, 32'h40);
        run_instr(rv32i_bp_pkg::op_br, rv32i_bp_pkg::beq, 32'h300, 0, 0, 32'h8);   // both tables
        look_up(32'h300);
        for (int k = 0; k < 40; k++) begin                       // overflow both tables
            run_instr(rv32i_bp_pkg::op_jal, rv32i_bp_pkg::beq, 32'h1000 + 4 * k, 0, 0, 32'h100);
            run_instr(rv32i_bp_pkg::op_br, rv32i_bp_pkg::bltu, 32'h2000 + 4 * k, 1, 2, 32'h10);
        end
        for (int k = 0; k < 40; k++) begin
            look_up(32'h1000 + 4 * k);
            look_up(32'h2000 + 4 * k);
        end
        for (int k = 0; k < 400; k++) begin                      // random streams on 8 pcs
            run_random_instr();
        end
        repeat (2) @(posedge clk);
        $display("checks done: %0d errors, %0d assertion failures over %0d instrs",
                 errors, UUT.u_buffer.u_chk.fails, updates);
        if (errors == 0 && UUT.u_buffer.u_chk.fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : bp_tb

//--- sim.f
rtl/rv32i_bp_pkg.sv
rtl/btb_entry.sv
rtl/jtb_entry.sv
rtl/control_buffer.sv
rtl/branch_resolve.sv
rtl/bp_top.sv
verif/bp_chk.sv
verif/bp_monitor.sv
verif/bp_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f sim.f --top-module bp_tb -o bp_sim
./obj_dir/bp_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
